/* verilog.f */
+incdir+design
design/memReqPkg.sv
design/ramBusPkg.sv
design/memReqIf.sv
design/byteBeatIf.sv
design/memArbiter.sv
design/byteSequencer.sv
design/wordAssembler.sv
design/memCtl.sv
tb/ramModel.sv
tb/memCtlTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memCtlTb
FILELIST  ?= verilog.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILDDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* tb/memCtlTb.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module memCtlTb;
    import memReqPkg::*;
    import ramBusPkg::*;

    localparam int wordBits   = `WORD_BYTES * 8;
    localparam int numFetch   = 150;
    localparam int numData    = 300;
    localparam int cycleLimit = 40 * (numFetch + numData) + 200;
    // fetches and data accesses use separate regions, so stores never race a fetch
    localparam int fetchBase  = 'h0_0400;
    localparam int dataBase   = 'h1_0800;
    localparam int regionSize = 512;

    logic                clk;
    logic                rst;
    logic                ramStall;
    logic                fetchValid;
    memAddr              fetchAddr;
    logic                fetchCredit;
    logic                fetchDone;
    logic [wordBits-1:0] fetchInst;
    logic                dataValid;
    logic                dataStore;
    logic                dataSigned;
    accessWidth          dataWidth;
    memAddr              dataAddr;
    logic [wordBits-1:0] dataWdata;
    logic                dataCredit;
    logic                dataDone;
    logic [wordBits-1:0] dataRdata;
    memAddr              ramAddr;
    logic                ramWrite;
    ramByte              ramWdata;
    ramByte              ramRdata;

    logic [31:0]         lfsrState = 32'hf340_c63a;
    ramByte              shadow [2**`MEM_ADDR_WIDTH];
    logic [wordBits-1:0] expFetch [$];
    logic [wordBits-1:0] expData [$];
    int                  fetchIssued = 0;
    int                  fetchReturned = 0;
    int                  dataIssued = 0;
    int                  dataReturned = 0;
    int                  storeBytesIssued = 0;
    int                  storeBytesWritten = 0;
    int                  fetchErrors = 0;
    int                  dataErrors = 0;
    int                  otherErrors = 0;
    int                  cycles = 0;

    memCtl i_dut (.*);

    ramModel uRam (
        .clk   (clk),
        .addr  (ramAddr),
        .write (ramWrite),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v         = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int byteCount(input accessWidth width);
        return (width == widthByte) ? 1 : (width == widthHalf) ? 2 : `WORD_BYTES;
    endfunction

    // any offset in the region that leaves room for a whole word, unaligned too
    function automatic memAddr pickAddr(input int base);
        int offset;
        offset = randBits(9);
        if (offset > regionSize - `WORD_BYTES) begin
            offset -= `WORD_BYTES;
        end
        return memAddr'(base + offset);
    endfunction

    // little-endian bytes from the shadow, top filled from the highest byte's sign
    function automatic logic [wordBits-1:0] expectLoad(input memAddr addr,
                                                       input accessWidth width,
                                                       input logic signedLoad);
        logic [wordBits-1:0] v;
        int                  n;
        n = byteCount(width);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = shadow[addr + memAddr'(i)];
        end
        if (signedLoad && v[8*n-1]) begin
            for (int i = 8 * n; i < wordBits; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic fillByte(input memAddr at);
        ramByte v;
        v          = ramByte'(randBits(8));
        shadow[at] = v;
        uRam.preload(at, v);
    endtask

    task automatic checkInst(input logic [wordBits-1:0] got, input logic [wordBits-1:0] exp);
        if (got !== exp) begin
            fetchErrors++;
            $display("CHECK FAILED fetchInst: got %h, expected %h", got, exp);
        end
    endtask

    task automatic checkData(input logic [wordBits-1:0] got, input logic [wordBits-1:0] exp);
        if (got !== exp) begin
            dataErrors++;
            $display("CHECK FAILED dataRdata: got %h, expected %h", got, exp);
        end
    endtask

    task automatic issueData();
        memAddr     a;
        accessWidth w;
        a = pickAddr(dataBase);
        w = accessWidth'(randBits(2) % 3);
        if (randBits(1) != 0) begin
            dataWdata = randBits(32);
            for (int i = 0; i < byteCount(w); i++) begin
                shadow[a + memAddr'(i)] = dataWdata[8*i +: 8];
            end
            storeBytesIssued += byteCount(w);
            dataStore = 1'b1;
        end else if (storeBytesWritten == storeBytesIssued) begin
            dataSigned = (randBits(1) != 0);
            expData.push_back(expectLoad(a, w, dataSigned));
            dataStore = 1'b0;
        end else begin
            // a store is still on its way to the RAM
            return;
        end
        dataAddr  = a;
        dataWidth = w;
        dataValid = 1'b1;
        dataIssued++;
    endtask

    // sampled just after the rising edge, while registered outputs hold
    always begin
        @(posedge clk);
        #1;
        if (!rst) begin
            if (fetchCredit) begin
                fetchReturned++;
            end
            if (dataCredit) begin
                dataReturned++;
            end
            if (fetchReturned > fetchIssued || dataReturned > dataIssued) begin
                otherErrors++;
                $display("a port got back more credits than it had spent");
            end
            if (fetchDone) begin
                if (expFetch.size() == 0) begin
                    otherErrors++;
                    $display("fetch result came with no fetch outstanding");
                end else begin
                    checkInst(fetchInst, expFetch.pop_front());
                end
            end
            if (dataDone) begin
                if (expData.size() == 0) begin
                    otherErrors++;
                    $display("load result came with no load outstanding");
                end else begin
                    checkData(dataRdata, expData.pop_front());
                end
            end
        end
    end

    // ramWrite follows ramStall, which changes on the falling edge
    always begin
        @(negedge clk);
        #1;
        if (!rst) begin
            if (ramWrite) begin
                storeBytesWritten++;
                if (ramStall) begin
                    otherErrors++;
                    $display("ramWrite was high while ramStall was high");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles with requests still open", cycles);
            $display("errors: fetch %0d, data %0d, other %0d",
                     fetchErrors, dataErrors, otherErrors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        ramStall   = 1'b0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        dataValid  = 1'b0;
        dataStore  = 1'b0;
        dataSigned = 1'b0;
        dataWidth  = widthByte;
        dataAddr   = '0;
        dataWdata  = '0;
        for (int a = 0; a < regionSize; a++) begin
            fillByte(memAddr'(fetchBase + a));
            fillByte(memAddr'(dataBase + a));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (fetchIssued < numFetch || dataIssued < numData) begin
            @(negedge clk);
            ramStall   = (randBits(3) == 0);
            fetchValid = 1'b0;
            dataValid  = 1'b0;
            if (fetchIssued < numFetch && fetchIssued - fetchReturned < `REQ_DEPTH
                && randBits(1) != 0) begin
                fetchAddr  = pickAddr(fetchBase);
                fetchValid = 1'b1;
                expFetch.push_back(expectLoad(fetchAddr, widthWord, 1'b0));
                fetchIssued++;
            end
            if (dataIssued < numData && dataIssued - dataReturned < `REQ_DEPTH
                && randBits(1) != 0) begin
                issueData();
            end
        end
        @(negedge clk);
        fetchValid = 1'b0;
        dataValid  = 1'b0;
        ramStall   = 1'b0;

        // all results back, all stores written, all credits home
        while (expFetch.size() != 0 || expData.size() != 0
               || storeBytesWritten != storeBytesIssued
               || fetchReturned != fetchIssued || dataReturned != dataIssued) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("errors: fetch %0d, data %0d, other %0d", fetchErrors, dataErrors, otherErrors);
        if (fetchErrors + dataErrors + otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb/ramModel.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module ramModel (
    input  logic              clk,
    input  memReqPkg::memAddr addr,
    input  logic              write,
    input  ramBusPkg::ramByte wdata,
    output ramBusPkg::ramByte rdata
);
    import ramBusPkg::*;

    ramByte mem [2**`MEM_ADDR_WIDTH];

    // read data shows up one cycle after its address
    always @(posedge clk) begin
        rdata <= mem[addr];
        if (write) begin
            mem[addr] = wdata;
        end
    end

    // backdoor load, used before reset ends
    task automatic preload(input memReqPkg::memAddr at, input ramByte value);
        mem[at] = value;
    endtask

endmodule

/* design/memCtl.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module memCtl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ramStall,

    input  logic                     fetchValid,
    input  memReqPkg::memAddr        fetchAddr,
    output logic                     fetchCredit,
    output logic                     fetchDone,
    output logic [`WORD_BYTES*8-1:0] fetchInst,

    input  logic                     dataValid,
    input  logic                     dataStore,
    input  logic                     dataSigned,
    input  memReqPkg::accessWidth    dataWidth,
    input  memReqPkg::memAddr        dataAddr,
    input  logic [`WORD_BYTES*8-1:0] dataWdata,
    output logic                     dataCredit,
    output logic                     dataDone,
    output logic [`WORD_BYTES*8-1:0] dataRdata,

    output memReqPkg::memAddr        ramAddr,
    output logic                     ramWrite,
    output ramBusPkg::ramByte        ramWdata,
    input  ramBusPkg::ramByte        ramRdata
);

    memReqIf   reqBus ();
    byteBeatIf beatBus ();

    memArbiter uArbiter (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchAddr   (fetchAddr),
        .dataValid   (dataValid),
        .dataStore   (dataStore),
        .dataSigned  (dataSigned),
        .dataWidth   (dataWidth),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .fetchCredit (fetchCredit),
        .dataCredit  (dataCredit),
        .reqOut      (reqBus.source)
    );

    byteSequencer uSequencer (
        .clk      (clk),
        .rst      (rst),
        .ramStall (ramStall),
        .reqIn    (reqBus.sink),
        .beatOut  (beatBus.source),
        .ramAddr  (ramAddr),
        .ramWrite (ramWrite),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    wordAssembler uAssembler (
        .clk       (clk),
        .rst       (rst),
        .beatIn    (beatBus.sink),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

endmodule

/* design/wordAssembler.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module wordAssembler (
    input  logic                     clk,
    input  logic                     rst,
    byteBeatIf.sink                  beatIn,
    output logic                     fetchDone,
    output logic [`WORD_BYTES*8-1:0] fetchInst,
    output logic                     dataDone,
    output logic [`WORD_BYTES*8-1:0] dataRdata
);
    import memReqPkg::*;
    import ramBusPkg::*;

    localparam int wordBits = `WORD_BYTES * 8;

    logic [wordBits-1:0] staging;
    logic [wordBits-1:0] merged;
    logic [wordBits-1:0] extended;
    logic                signBit;
    byteLane             prevLane;
    logic                prevLast;
    logic                finish;

    // final byte lands in the same cycle as last
    always_comb begin
        merged = staging;
        merged[{beatIn.lane, 3'b000} +: 8] = beatIn.data;
    end

    always_comb begin
        case (beatIn.width)
            widthByte: begin
                signBit  = beatIn.signedLoad && merged[7];
                extended = {{(wordBits - 8){signBit}}, merged[7:0]};
            end
            widthHalf: begin
                signBit  = beatIn.signedLoad && merged[15];
                extended = {{(wordBits - 16){signBit}}, merged[15:0]};
            end
            default: begin
                signBit  = 1'b0;
                extended = merged;
            end
        endcase
    end

    assign finish = beatIn.beat && beatIn.last;

    always_ff @(posedge clk) begin
        if (beatIn.beat) begin
            staging  <= merged;
            prevLane <= beatIn.lane;
        end
        if (finish) begin
            fetchInst <= merged;
            dataRdata <= extended;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            prevLast  <= 1'b1;
        end else begin
            fetchDone <= finish && (beatIn.op == opFetch);
            dataDone  <= finish && (beatIn.op == opLoad);
            if (beatIn.beat) begin
                prevLast <= beatIn.last;
            end
        end
    end

    // bytes of one access arrive in lane order with no gaps
    laneOrder: assert property (@(posedge clk) disable iff (rst)
        beatIn.beat |-> (prevLast ? (beatIn.lane == '0)
                                  : (beatIn.lane == byteLane'(prevLane + 1'b1))));

endmodule

/* design/byteSequencer.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module byteSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              ramStall,
    memReqIf.sink             reqIn,
    byteBeatIf.source         beatOut,
    output memReqPkg::memAddr ramAddr,
    output logic              ramWrite,
    output ramBusPkg::ramByte ramWdata,
    input  ramBusPkg::ramByte ramRdata
);
    import memReqPkg::*;
    import ramBusPkg::*;

    memReq   cur;
    logic    busy;
    byteLane laneCnt;
    byteLane finalLane;
    logic    issue;
    logic    lastByte;
    logic    take;

    // read in flight, lines up with the RAM byte one cycle later
    logic       pendBeat;
    byteLane    pendLane;
    logic       pendLast;
    memOp       pendOp;
    accessWidth pendWidth;
    logic       pendSigned;

    always_comb begin
        case (cur.width)
            widthByte: finalLane = byteLane'(0);
            widthHalf: finalLane = byteLane'(1);
            default:   finalLane = byteLane'(`WORD_BYTES - 1);
        endcase
    end

    assign issue    = busy && !ramStall;
    assign lastByte = (laneCnt == finalLane);

    // next request is taken during the final byte so the bytes run back to back
    assign reqIn.ready = !busy || (issue && lastByte);
    assign take        = reqIn.valid && reqIn.ready;

    assign ramAddr  = cur.addr + memAddr'(laneCnt);
    assign ramWrite = issue && (cur.op == opStore);
    assign ramWdata = cur.wdata[{laneCnt, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            laneCnt  <= '0;
            pendBeat <= 1'b0;
        end else begin
            pendBeat <= issue && (cur.op != opStore);
            if (issue) begin
                if (lastByte) begin
                    busy <= 1'b0;
                end else begin
                    laneCnt <= laneCnt + 1'b1;
                end
            end
            if (take) begin
                busy    <= 1'b1;
                laneCnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cur <= reqIn.req;
        end
        if (issue) begin
            pendLane   <= laneCnt;
            pendLast   <= lastByte;
            pendOp     <= cur.op;
            pendWidth  <= cur.width;
            pendSigned <= cur.signedLoad;
        end
    end

    assign beatOut.beat       = pendBeat;
    assign beatOut.data       = ramRdata;
    assign beatOut.lane       = pendLane;
    assign beatOut.last       = pendLast;
    assign beatOut.op         = pendOp;
    assign beatOut.width      = pendWidth;
    assign beatOut.signedLoad = pendSigned;

    // an offer that was not taken stays on the bus unchanged
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        reqIn.valid && !reqIn.ready |=> reqIn.valid && $stable(reqIn.req));

endmodule

/* design/memArbiter.sv */
`timescale 1ns/1ps
`include "memCtl_params.svh"

module memArbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetchValid,
    input  memReqPkg::memAddr        fetchAddr,
    input  logic                     dataValid,
    input  logic                     dataStore,
    input  logic                     dataSigned,
    input  memReqPkg::accessWidth    dataWidth,
    input  memReqPkg::memAddr        dataAddr,
    input  logic [`WORD_BYTES*8-1:0] dataWdata,
    output logic                     fetchCredit,
    output logic                     dataCredit,
    memReqIf.source                  reqOut
);
    import memReqPkg::*;

    localparam int depth    = `REQ_DEPTH;
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);

    // index 0 is the fetch port, index 1 the data port
    logic [1:0] push;
    logic [1:0] pop;
    logic [1:0] notEmpty;
    memReq      inReq [2];
    memReq      head [2];
    logic       selData;
    logic       holdFetch;

    function automatic logic [ptrWidth-1:0] bumpPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = {dataValid, fetchValid};

    always_comb begin
        inReq[0].op         = opFetch;
        inReq[0].addr       = fetchAddr;
        inReq[0].width      = widthWord;
        inReq[0].signedLoad = 1'b0;
        inReq[0].wdata      = '0;
        inReq[1].op         = dataStore ? opStore : opLoad;
        inReq[1].addr       = dataAddr;
        inReq[1].width      = dataWidth;
        inReq[1].signedLoad = dataSigned;
        inReq[1].wdata      = dataWdata;
    end

    for (genvar port = 0; port < 2; port++) begin : gPort
        memReq               mem [depth];
        logic [ptrWidth-1:0] wrPtr;
        logic [ptrWidth-1:0] rdPtr;
        logic [cntWidth-1:0] count;

        always_ff @(posedge clk) begin
            if (push[port]) begin
                mem[wrPtr] <= inReq[port];
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wrPtr <= '0;
                rdPtr <= '0;
                count <= '0;
            end else begin
                if (push[port]) begin
                    wrPtr <= bumpPtr(wrPtr);
                end
                if (pop[port]) begin
                    rdPtr <= bumpPtr(rdPtr);
                end
                if (push[port] && !pop[port]) begin
                    count <= count + 1'b1;
                end else if (!push[port] && pop[port]) begin
                    count <= count - 1'b1;
                end
            end
        end

        assign notEmpty[port] = (count != '0);
        assign head[port]     = mem[rdPtr];

        // credit comes back a cycle after the pop, so a full buffer never sees a push
        noOverrun: assert property (@(posedge clk) disable iff (rst)
            push[port] |-> count != cntWidth'(depth));
    end

    // data wins unless a fetch is already on offer
    assign selData      = notEmpty[1] && !holdFetch;
    assign reqOut.valid = |notEmpty;
    assign reqOut.req   = selData ? head[1] : head[0];
    assign pop[1]       = reqOut.valid && reqOut.ready && selData;
    assign pop[0]       = reqOut.valid && reqOut.ready && !selData;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchCredit <= 1'b0;
            dataCredit  <= 1'b0;
            holdFetch   <= 1'b0;
        end else begin
            fetchCredit <= pop[0];
            dataCredit  <= pop[1];
            holdFetch   <= reqOut.valid && !reqOut.ready && !selData;
        end
    end

endmodule

/* design/byteBeatIf.sv */
`timescale 1ns/1ps

interface byteBeatIf;
    import memReqPkg::*;
    import ramBusPkg::*;

    logic       beat;
    ramByte     data;
    byteLane    lane;
    logic       last;
    memOp       op;
    accessWidth width;
    logic       signedLoad;

    // no ready, the sink takes every beat
    modport source (
        output beat,
        output data,
        output lane,
        output last,
        output op,
        output width,
        output signedLoad
    );

    modport sink (
        input beat,
        input data,
        input lane,
        input last,
        input op,
        input width,
        input signedLoad
    );

endinterface

/* design/memReqIf.sv */
`timescale 1ns/1ps

interface memReqIf;
    import memReqPkg::*;

    logic  valid;
    logic  ready;
    memReq req;

    // req stays put until the edge with valid and ready both high
    modport source (
        output valid,
        output req,
        input  ready
    );

    modport sink (
        input  valid,
        input  req,
        output ready
    );

endinterface

/* design/ramBusPkg.sv */
`include "memCtl_params.svh"

package ramBusPkg;

    // one RAM location
    typedef logic [7:0] ramByte;

    // byte position within a word, lane 0 is the lowest address
    typedef logic [$clog2(`WORD_BYTES)-1:0] byteLane;

endpackage

/* design/memReqPkg.sv */
`include "memCtl_params.svh"

package memReqPkg;

    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } memOp;

    typedef enum logic [1:0] {
        widthByte,
        widthHalf,
        widthWord
    } accessWidth;

    typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr;

    // one request as it sits in a port buffer
    typedef struct packed {
        memOp                      op;
        memAddr                    addr;
        accessWidth                width;
        logic                      signedLoad;
        logic [`WORD_BYTES*8-1:0]  wdata;
    } memReq;

endpackage

/* design/memCtl_params.svh */
`ifndef MEMCTL_PARAMS_SVH
`define MEMCTL_PARAMS_SVH

// byte address into the RAM
`define MEM_ADDR_WIDTH 17

// buffer entries per port, also the credits a port starts with
`define REQ_DEPTH 2

// bytes in one word
`define WORD_BYTES 4

`endif
